/* logic/ntt_bf2x2_top.sv */
`timescale 1ns/1ps

module ntt_bf2x2_top #(
    parameter int BF_LATENCY = 4,
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize_i,
    input  logic              req_i,
    input  ntt_pkg::op_mode_t mode_i,
    input  ntt_pkg::coeff_t   a0_i, a1_i, a2_i, a3_i,
    input  ntt_pkg::coeff_t   b0_i, b1_i, b2_i, b3_i,
    input  ntt_pkg::coeff_t   w0_i, w1_i, w2_i, w3_i,
    output logic              ack_o,
    input  logic              out_ack_i,
    output logic              out_req_o,
    output ntt_pkg::coeff_t   out_r0_o, out_r1_o, out_r2_o, out_r3_o
);

    import ntt_pkg::*;

    // Intake to core
    logic     issue;
    op_mode_t op_mode;
    coeff_t   op_a0, op_a1, op_a2, op_a3;
    coeff_t   op_b0, op_b1, op_b2, op_b3;
    coeff_t   op_w0, op_w1, op_w2, op_w3;
    // Core to queue
    logic     res_valid;
    coeff_t   res0, res1, res2, res3;
    // Credit return
    logic     pop;

    ntt_op_intake #(.FIFO_DEPTH(FIFO_DEPTH)) ntt_op_intake_inst (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .req_i(req_i), .mode_i(mode_i),
        .a0_i(a0_i), .a1_i(a1_i), .a2_i(a2_i), .a3_i(a3_i),
        .b0_i(b0_i), .b1_i(b1_i), .b2_i(b2_i), .b3_i(b3_i),
        .w0_i(w0_i), .w1_i(w1_i), .w2_i(w2_i), .w3_i(w3_i),
        .pop_i(pop), .ack_o(ack_o), .issue_o(issue), .mode_o(op_mode),
        .a0_o(op_a0), .a1_o(op_a1), .a2_o(op_a2), .a3_o(op_a3),
        .b0_o(op_b0), .b1_o(op_b1), .b2_o(op_b2), .b3_o(op_b3),
        .w0_o(op_w0), .w1_o(op_w1), .w2_o(op_w2), .w3_o(op_w3)
    );

    // Fixed 2*BF_LATENCY core
    ntt_hybrid_butterfly_2x2 #(.BF_LATENCY(BF_LATENCY)) ntt_hybrid_butterfly_2x2_inst (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .issue_i(issue), .mode_i(op_mode),
        .a0_i(op_a0), .a1_i(op_a1), .a2_i(op_a2), .a3_i(op_a3),
        .b0_i(op_b0), .b1_i(op_b1), .b2_i(op_b2), .b3_i(op_b3),
        .w0_i(op_w0), .w1_i(op_w1), .w2_i(op_w2), .w3_i(op_w3),
        .valid_o(res_valid), .r0_o(res0), .r1_o(res1), .r2_o(res2), .r3_o(res3)
    );

    ntt_result_queue #(.FIFO_DEPTH(FIFO_DEPTH)) ntt_result_queue_inst (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .valid_i(res_valid), .r0_i(res0), .r1_i(res1), .r2_i(res2), .r3_i(res3),
        .out_ack_i(out_ack_i), .out_req_o(out_req_o),
        .out_r0_o(out_r0_o), .out_r1_o(out_r1_o), .out_r2_o(out_r2_o), .out_r3_o(out_r3_o),
        .pop_o(pop)
    );

endmodule

/* logic/ntt_butterfly.sv */
`timescale 1ns/1ps

module ntt_butterfly #(
    parameter int BF_LATENCY = 4
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize_i,
    input  ntt_pkg::op_mode_t mode_i,
    input  ntt_pkg::coeff_t   u_i,
    input  ntt_pkg::coeff_t   v_i,
    input  ntt_pkg::coeff_t   w_i,
    output ntt_pkg::coeff_t   u_o,
    output ntt_pkg::coeff_t   v_o
);

    import ntt_pkg::*;

    // Three inner stages, the rest is the post stage plus output padding
    localparam int PAD = BF_LATENCY - 3;

    // Operands are below Q on entry
    function automatic coeff_t mod_add(coeff_t a, coeff_t b);
        logic [COEFF_W:0] s;
        s = {1'b0, a} + {1'b0, b};
        if (s >= {1'b0, NTT_Q}) begin
            s = s - {1'b0, NTT_Q};
        end
        return s[COEFF_W-1:0];
    endfunction

    function automatic coeff_t mod_sub(coeff_t a, coeff_t b);
        logic [COEFF_W:0] d;
        // Borrow is folded back by adding Q
        d = (a >= b) ? ({1'b0, a} - {1'b0, b}) : ({1'b0, a} + {1'b0, NTT_Q} - {1'b0, b});
        return d[COEFF_W-1:0];
    endfunction

    // Mode tags, one per stage
    op_mode_t s1_mode, s2_mode, s3_mode;
    // Stage 1: addend and the two multiplier operands
    coeff_t   s1_a, s1_b, s1_m;
    // Stage 2: raw product
    coeff_t   s2_a;
    prod_t    s2_p;
    // Stage 3: reduced product
    coeff_t   s3_a, s3_r;
    // Stage 4 and padding
    coeff_t   u_pipe [PAD];
    coeff_t   v_pipe [PAD];

    coeff_t      uv_sum, uv_dif;
    coeff_t      pre_a, pre_b, pre_m;
    logic [71:0] bar_t;
    logic [23:0] bar_q;
    logic [24:0] bar_r;
    coeff_t      red_r;
    coeff_t      post_u, post_v;

    // ------------------------------------------------------------------
    // Pre-add, selects what gets multiplied
    // ------------------------------------------------------------------
    always_comb begin
        uv_sum = mod_add(u_i, v_i);
        uv_dif = mod_sub(u_i, v_i);
        pre_a  = '0;
        pre_b  = '0;
        pre_m  = w_i;
        case (mode_i)
            MODE_CT: begin
                // w*v computed below, u waits
                pre_a = u_i;
                pre_b = v_i;
            end
            MODE_GS: begin
                // (u-v)*w, u+v waits
                pre_a = uv_sum;
                pre_b = uv_dif;
            end
            MODE_PWM: begin
                pre_b = u_i;
                pre_m = v_i;
            end
            MODE_PWA: pre_a = uv_sum;
            MODE_PWS: pre_a = uv_dif;
            default: ;
        endcase
    end

    // ------------------------------------------------------------------
    // Barrett reduction, one conditional subtract suffices for p < 2^46
    // ------------------------------------------------------------------
    always_comb begin
        bar_t = s2_p * BARRETT_MU;
        bar_q = bar_t[71:48];
        // Only the low 25 bits matter, remainder is below 2Q
        bar_r = s2_p[24:0] - bar_q * NTT_Q;
        if (bar_r >= {2'b00, NTT_Q}) begin
            bar_r = bar_r - {2'b00, NTT_Q};
        end
        red_r = bar_r[COEFF_W-1:0];
    end

    // Post add/sub
    always_comb begin
        post_u = s3_a;
        post_v = '0;
        case (s3_mode)
            MODE_CT: begin
                post_u = mod_add(s3_a, s3_r);
                post_v = mod_sub(s3_a, s3_r);
            end
            MODE_GS:  post_v = s3_r;
            MODE_PWM: post_u = s3_r;
            default: ;
        endcase
    end

    // Mode tags
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_mode <= MODE_CT;
            s2_mode <= MODE_CT;
            s3_mode <= MODE_CT;
        end else if (zeroize_i) begin
            s1_mode <= MODE_CT;
            s2_mode <= MODE_CT;
            s3_mode <= MODE_CT;
        end else begin
            s1_mode <= mode_i;
            s2_mode <= s1_mode;
            s3_mode <= s2_mode;
        end
    end

    // Datapath registers
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            {s1_a, s1_b, s1_m} <= '0;
            {s2_a, s2_p} <= '0;
            {s3_a, s3_r} <= '0;
            u_pipe <= '{default: '0};
            v_pipe <= '{default: '0};
        end else begin
            s1_a      <= pre_a;
            s1_b      <= pre_b;
            s1_m      <= pre_m;
            s2_a      <= s1_a;
            s2_p      <= s1_b * s1_m;
            s3_a      <= s2_a;
            s3_r      <= red_r;
            u_pipe[0] <= post_u;
            v_pipe[0] <= post_v;
            for (int i = 1; i < PAD; i++) begin
                u_pipe[i] <= u_pipe[i-1];
                v_pipe[i] <= v_pipe[i-1];
            end
        end
    end

    assign u_o = u_pipe[PAD-1];
    assign v_o = v_pipe[PAD-1];

endmodule

/* logic/ntt_hybrid_butterfly_2x2.sv */
`timescale 1ns/1ps

module ntt_hybrid_butterfly_2x2 #(
    parameter int BF_LATENCY = 4
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize_i,
    input  logic              issue_i,
    input  ntt_pkg::op_mode_t mode_i,
    input  ntt_pkg::coeff_t   a0_i, a1_i, a2_i, a3_i,
    input  ntt_pkg::coeff_t   b0_i, b1_i, b2_i, b3_i,
    input  ntt_pkg::coeff_t   w0_i, w1_i, w2_i, w3_i,
    output logic              valid_o,
    output ntt_pkg::coeff_t   r0_o, r1_o, r2_o, r3_o
);

    import ntt_pkg::*;

    // Two butterflies in series, every mode
    localparam int CORE_LAT = 2 * BF_LATENCY;

    // Ops in flight
    logic     vld_sr  [CORE_LAT];
    op_mode_t mode_sr [CORE_LAT];
    logic     pw_s2, pw_out;

    // Bypass of stage 1: w2, w3, a2, b2, a3, b3
    coeff_t lane_dly [BF_LATENCY][6];
    // Pointwise lanes 0 and 1 after stage 1
    coeff_t res_dly  [BF_LATENCY][2];

    coeff_t bf00_u, bf00_v, bf01_u, bf01_v;
    coeff_t bf10_u, bf10_v, bf11_u, bf11_v;
    coeff_t bf10_u_in, bf10_v_in, bf11_u_in, bf11_v_in;

    // Mode at stage 2 entry and at the output
    assign pw_s2  = mode_sr[BF_LATENCY-1] inside {MODE_PWM, MODE_PWA, MODE_PWS};
    assign pw_out = mode_sr[CORE_LAT-1] inside {MODE_PWM, MODE_PWA, MODE_PWS};

    // ------------------------------------------------------------------
    // Stage 1, lanes 0 and 1 in every mode
    // ------------------------------------------------------------------
    ntt_butterfly #(.BF_LATENCY(BF_LATENCY)) bf00 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .mode_i(mode_i),
        .u_i(a0_i), .v_i(b0_i), .w_i(w0_i), .u_o(bf00_u), .v_o(bf00_v)
    );

    ntt_butterfly #(.BF_LATENCY(BF_LATENCY)) bf01 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .mode_i(mode_i),
        .u_i(a1_i), .v_i(b1_i), .w_i(w1_i), .u_o(bf01_u), .v_o(bf01_v)
    );

    // Stage 2 takes stage 1 results for NTT, delayed lanes 2/3 otherwise
    assign bf10_u_in = pw_s2 ? lane_dly[BF_LATENCY-1][2] : bf00_u;
    assign bf10_v_in = pw_s2 ? lane_dly[BF_LATENCY-1][3] : bf01_u;
    assign bf11_u_in = pw_s2 ? lane_dly[BF_LATENCY-1][4] : bf00_v;
    assign bf11_v_in = pw_s2 ? lane_dly[BF_LATENCY-1][5] : bf01_v;

    // ------------------------------------------------------------------
    // Stage 2
    // ------------------------------------------------------------------
    ntt_butterfly #(.BF_LATENCY(BF_LATENCY)) bf10 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .mode_i(mode_sr[BF_LATENCY-1]), .u_i(bf10_u_in), .v_i(bf10_v_in),
        .w_i(lane_dly[BF_LATENCY-1][0]), .u_o(bf10_u), .v_o(bf10_v)
    );

    ntt_butterfly #(.BF_LATENCY(BF_LATENCY)) bf11 (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i),
        .mode_i(mode_sr[BF_LATENCY-1]), .u_i(bf11_u_in), .v_i(bf11_v_in),
        .w_i(lane_dly[BF_LATENCY-1][1]), .u_o(bf11_u), .v_o(bf11_v)
    );

    // Pointwise lane order: 0,1 delayed from stage 1, 2,3 from stage 2
    assign r0_o = pw_out ? res_dly[BF_LATENCY-1][0] : bf10_u;
    assign r1_o = pw_out ? res_dly[BF_LATENCY-1][1] : bf10_v;
    assign r2_o = pw_out ? bf10_u : bf11_u;
    assign r3_o = pw_out ? bf11_u : bf11_v;

    assign valid_o = vld_sr[CORE_LAT-1];

    // Valid/mode tracking
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            vld_sr  <= '{default: 1'b0};
            mode_sr <= '{default: MODE_CT};
        end else if (zeroize_i) begin
            vld_sr  <= '{default: 1'b0};
            mode_sr <= '{default: MODE_CT};
        end else begin
            vld_sr[0]  <= issue_i;
            mode_sr[0] <= mode_i;
            for (int i = 1; i < CORE_LAT; i++) begin
                vld_sr[i]  <= vld_sr[i-1];
                mode_sr[i] <= mode_sr[i-1];
            end
        end
    end

    // Delay lines, BF_LATENCY deep
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            lane_dly <= '{default: '0};
            res_dly  <= '{default: '0};
        end else begin
            lane_dly[0] <= '{w2_i, w3_i, a2_i, b2_i, a3_i, b3_i};
            res_dly[0]  <= '{bf00_u, bf01_u};
            for (int i = 1; i < BF_LATENCY; i++) begin
                lane_dly[i] <= lane_dly[i-1];
                res_dly[i]  <= res_dly[i-1];
            end
        end
    end

endmodule

/* logic/ntt_op_intake.sv */
`timescale 1ns/1ps

module ntt_op_intake #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic              clk,
    input  logic              reset_n,
    input  logic              zeroize_i,
    input  logic              req_i,
    input  ntt_pkg::op_mode_t mode_i,
    input  ntt_pkg::coeff_t   a0_i, a1_i, a2_i, a3_i,
    input  ntt_pkg::coeff_t   b0_i, b1_i, b2_i, b3_i,
    input  ntt_pkg::coeff_t   w0_i, w1_i, w2_i, w3_i,
    input  logic              pop_i,
    output logic              ack_o,
    output logic              issue_o,
    output ntt_pkg::op_mode_t mode_o,
    output ntt_pkg::coeff_t   a0_o, a1_o, a2_o, a3_o,
    output ntt_pkg::coeff_t   b0_o, b1_o, b2_o, b3_o,
    output ntt_pkg::coeff_t   w0_o, w1_o, w2_o, w3_o
);

    import ntt_pkg::*;

    // Counts in flight plus queued results, 0..FIFO_DEPTH
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        IDLE,
        ACKED,
        WAIT_LOW
    } hs_state_t;

    hs_state_t        state_q;
    logic [CNT_W-1:0] credit_q;
    logic             accept;

    // New operation only with a free result slot
    assign accept = (state_q == IDLE) && req_i && (credit_q < FIFO_DEPTH);
    assign ack_o  = (state_q == ACKED);

    // ------------------------------------------------------------------
    // Four-phase handshake and credit count
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q  <= IDLE;
            issue_o  <= 1'b0;
            credit_q <= '0;
        end else if (zeroize_i) begin
            state_q  <= IDLE;
            issue_o  <= 1'b0;
            credit_q <= '0;
        end else begin
            issue_o <= accept;
            case (state_q)
                IDLE:  if (accept) state_q <= ACKED;
                // Hold ack until the requester lets go
                ACKED: if (!req_i) state_q <= WAIT_LOW;
                // ack has fallen, handshake closes
                default: state_q <= IDLE;
            endcase
            // Up on issue, down on pop
            if (issue_o && !pop_i) begin
                credit_q <= credit_q + 1'b1;
            end else if (!issue_o && pop_i) begin
                credit_q <= credit_q - 1'b1;
            end
        end
    end

    // Operand capture, held for the core
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            mode_o                   <= MODE_CT;
            {a0_o, a1_o, a2_o, a3_o} <= '0;
            {b0_o, b1_o, b2_o, b3_o} <= '0;
            {w0_o, w1_o, w2_o, w3_o} <= '0;
        end else if (accept) begin
            mode_o                   <= mode_i;
            {a0_o, a1_o, a2_o, a3_o} <= {a0_i, a1_i, a2_i, a3_i};
            {b0_o, b1_o, b2_o, b3_o} <= {b0_i, b1_i, b2_i, b3_i};
            {w0_o, w1_o, w2_o, w3_o} <= {w0_i, w1_i, w2_i, w3_i};
        end
    end

endmodule

/* logic/ntt_pkg.sv */
package ntt_pkg;

    // ------------------------------------------------------------------
    // ML-DSA arithmetic constants
    // ------------------------------------------------------------------

    // Coefficient width
    localparam int COEFF_W = 23;

    // Prime modulus, 2^23 - 2^13 + 1
    localparam logic [COEFF_W-1:0] NTT_Q = 23'd8380417;

    // floor(2^48 / Q), reduction of products below 2^46
    localparam logic [25:0] BARRETT_MU = 26'd33587228;

    // ------------------------------------------------------------------
    // Datapath types
    // ------------------------------------------------------------------

    // Residue modulo Q
    typedef logic [COEFF_W-1:0] coeff_t;

    // Unreduced product of two residues
    typedef logic [2*COEFF_W-1:0] prod_t;

    // Core operating modes
    typedef enum logic [2:0] {
        // Forward NTT butterfly
        MODE_CT  = 3'd0,
        // Inverse NTT butterfly
        MODE_GS  = 3'd1,
        // Pointwise multiply, add, subtract
        MODE_PWM = 3'd2,
        MODE_PWA = 3'd3,
        MODE_PWS = 3'd4
    } op_mode_t;

endpackage

/* logic/ntt_result_queue.sv */
`timescale 1ns/1ps

module ntt_result_queue #(
    parameter int FIFO_DEPTH = 4
) (
    input  logic            clk,
    input  logic            reset_n,
    input  logic            zeroize_i,
    input  logic            valid_i,
    input  ntt_pkg::coeff_t r0_i, r1_i, r2_i, r3_i,
    input  logic            out_ack_i,
    output logic            out_req_o,
    output ntt_pkg::coeff_t out_r0_o, out_r1_o, out_r2_o, out_r3_o,
    output logic            pop_o
);

    import ntt_pkg::*;

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    typedef enum logic [1:0] {
        EMPTY_WAIT,
        REQ,
        ACK_LOW
    } out_state_t;

    out_state_t       state_q;
    logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic             pop;
    logic             has_data;
    coeff_t           mem [FIFO_DEPTH][4];

    // Wrap at depth, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_next(logic [PTR_W-1:0] p);
        return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    // Entry leaves when the consumer acknowledges
    assign pop = (state_q == REQ) && out_ack_i;
    // A write this cycle counts, so req rises right after it
    assign has_data = (count_q != '0) || valid_i;

    // ------------------------------------------------------------------
    // Pointers, fill level and output handshake
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q  <= EMPTY_WAIT;
            {wr_ptr_q, rd_ptr_q, count_q} <= '0;
            pop_o    <= 1'b0;
        end else if (zeroize_i) begin
            state_q  <= EMPTY_WAIT;
            {wr_ptr_q, rd_ptr_q, count_q} <= '0;
            pop_o    <= 1'b0;
        end else begin
            pop_o <= pop;
            if (valid_i) wr_ptr_q <= ptr_next(wr_ptr_q);
            if (pop) rd_ptr_q <= ptr_next(rd_ptr_q);
            if (valid_i && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (!valid_i && pop) begin
                count_q <= count_q - 1'b1;
            end
            case (state_q)
                EMPTY_WAIT: if (has_data) state_q <= REQ;
                REQ:        if (out_ack_i) state_q <= ACK_LOW;
                // Next req only once ack is back low
                default:    if (!out_ack_i) state_q <= has_data ? REQ : EMPTY_WAIT;
            endcase
        end
    end

    // Storage, credits in the intake keep it from overflowing
    always_ff @(posedge clk) begin
        if (zeroize_i) begin
            mem <= '{default: '0};
        end else if (valid_i) begin
            mem[wr_ptr_q] <= '{r0_i, r1_i, r2_i, r3_i};
        end
    end

    assign out_req_o = (state_q == REQ);
    assign out_r0_o  = mem[rd_ptr_q][0];
    assign out_r1_o  = mem[rd_ptr_q][1];
    assign out_r2_o  = mem[rd_ptr_q][2];
    assign out_r3_o  = mem[rd_ptr_q][3];

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator and run, pass is decided by the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module ntt_bf2x2_tb \
    -f sources.f -o sim_ntt_bf2x2 &&
./obj_dir/sim_ntt_bf2x2 | tee /dev/stderr | grep -qF '*** PASSED ***' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* sources.f */
logic/ntt_pkg.sv
logic/ntt_butterfly.sv
logic/ntt_op_intake.sv
logic/ntt_hybrid_butterfly_2x2.sv
logic/ntt_result_queue.sv
logic/ntt_bf2x2_top.sv
tb/ntt_bf2x2_properties.sv
tb/ntt_bf2x2_tb.sv

/* tb/ntt_bf2x2_properties.sv */
`timescale 1ns/1ps

module ntt_bf2x2_properties (
    input logic            clk,
    input logic            reset_n,
    input logic            zeroize_i,
    input logic            req_i,
    input logic            ack_o,
    input logic            out_req_o,
    input logic            out_ack_i,
    input ntt_pkg::coeff_t out_r0_o, out_r1_o, out_r2_o, out_r3_o
);

    import ntt_pkg::*;

    // ------------------------------------------------------------------
    // Input handshake
    // ------------------------------------------------------------------
    // Ack holds as long as the requester keeps req up, zeroize ends it
    assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        ack_o && req_i && !zeroize_i |=> ack_o)
        else $error("ack_o dropped while req_i was high");

    // Output request holds until the consumer acknowledges
    assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        out_req_o && !out_ack_i && !zeroize_i |=> out_req_o)
        else $error("out_req_o dropped before out_ack_i");

    // Results are reduced residues
    assert property (@(posedge clk) disable iff (!reset_n || zeroize_i)
        out_req_o |-> (out_r0_o < NTT_Q) && (out_r1_o < NTT_Q)
                      && (out_r2_o < NTT_Q) && (out_r3_o < NTT_Q))
        else $error("output lane not below Q");

endmodule

bind ntt_bf2x2_top ntt_bf2x2_properties ntt_bf2x2_properties_inst (
    .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .req_i(req_i), .ack_o(ack_o),
    .out_req_o(out_req_o), .out_ack_i(out_ack_i),
    .out_r0_o(out_r0_o), .out_r1_o(out_r1_o), .out_r2_o(out_r2_o), .out_r3_o(out_r3_o)
);

/* tb/ntt_bf2x2_tb.sv */
`timescale 1ns/1ps

module ntt_bf2x2_tb;

    import ntt_pkg::*;

    localparam int BF_LATENCY = 4;
    localparam int FIFO_DEPTH = 4;
    localparam int MAX_ENT    = 40;
    localparam int MAX_DELAY  = 20;
    localparam int WAIT_LIMIT = 400;
    localparam longint QL     = longint'(NTT_Q);

    typedef struct {
        op_mode_t mode;
        coeff_t   a [4];
        coeff_t   b [4];
        coeff_t   w [4];
        coeff_t   r [4];
    } entry_t;

    logic     clk, reset_n, zeroize_i, req_i, out_ack_i;
    op_mode_t mode_i;
    coeff_t   a0_i, a1_i, a2_i, a3_i, b0_i, b1_i, b2_i, b3_i, w0_i, w1_i, w2_i, w3_i;
    logic     ack_o, out_req_o;
    coeff_t   out_r0_o, out_r1_o, out_r2_o, out_r3_o;

    entry_t      tbl [MAX_ENT];
    int          n_ent, errors, checks, tests, failed_tests, cycles, timeout_limit;
    int          issued, consumed;
    logic [22:0] lfsr_q;

    ntt_bf2x2_top #(.BF_LATENCY(BF_LATENCY), .FIFO_DEPTH(FIFO_DEPTH)) ntt_bf2x2_top_inst (
        .clk(clk), .reset_n(reset_n), .zeroize_i(zeroize_i), .req_i(req_i), .mode_i(mode_i),
        .a0_i(a0_i), .a1_i(a1_i), .a2_i(a2_i), .a3_i(a3_i),
        .b0_i(b0_i), .b1_i(b1_i), .b2_i(b2_i), .b3_i(b3_i),
        .w0_i(w0_i), .w1_i(w1_i), .w2_i(w2_i), .w3_i(w3_i),
        .ack_o(ack_o), .out_ack_i(out_ack_i), .out_req_o(out_req_o),
        .out_r0_o(out_r0_o), .out_r1_o(out_r1_o), .out_r2_o(out_r2_o), .out_r3_o(out_r3_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Run limit, every entry gets a full round trip plus the slowest consumer
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > timeout_limit) begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ------------------------------------------------------------------
    // Modular arithmetic of the reference model
    // ------------------------------------------------------------------
    function automatic coeff_t m_add(coeff_t x, coeff_t y);
        return coeff_t'((longint'(x) + longint'(y)) % QL);
    endfunction

    function automatic coeff_t m_sub(coeff_t x, coeff_t y);
        return coeff_t'((longint'(x) - longint'(y) + QL) % QL);
    endfunction

    function automatic coeff_t m_mul(coeff_t x, coeff_t y);
        return coeff_t'((longint'(x) * longint'(y)) % QL);
    endfunction

    // Fermat inverse, w^(Q-2)
    function automatic coeff_t m_inv(coeff_t w);
        coeff_t r, base;
        longint e;
        r = 23'd1;
        base = w;
        e = QL - 2;
        while (e > 0) begin
            if (e[0]) r = m_mul(r, base);
            base = m_mul(base, base);
            e = e >> 1;
        end
        return r;
    endfunction

    // Fibonacci LFSR x^23 + x^18 + 1, one step per bit
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[22] ^ lfsr_q[17];
        lfsr_q = {lfsr_q[21:0], fb};
        return fb;
    endfunction

    function automatic coeff_t rand_coeff();
        logic [22:0] v;
        v = '0;
        for (int i = 0; i < 23; i++) v = {v[21:0], lfsr_bit()};
        return coeff_t'(longint'(v) % QL);
    endfunction

    // ------------------------------------------------------------------
    // Table construction with expected results
    // ------------------------------------------------------------------
    task automatic add_op(input op_mode_t m, input coeff_t a0, a1, a2, a3,
                          input coeff_t b0, b1, b2, b3, input coeff_t w0, w1, w2, w3);
        entry_t e;
        coeff_t p, q, s, t;
        e.mode = m;
        e.a = '{a0, a1, a2, a3};
        e.b = '{b0, b1, b2, b3};
        e.w = '{w0, w1, w2, w3};
        case (m)
            MODE_CT: begin
                // Stage 1 on (a0,b0) and (a1,b1), stage 2 pairs the u and v outputs
                p = m_add(a0, m_mul(w0, b0));
                q = m_sub(a0, m_mul(w0, b0));
                s = m_add(a1, m_mul(w1, b1));
                t = m_sub(a1, m_mul(w1, b1));
                e.r = '{m_add(p, m_mul(w2, s)), m_sub(p, m_mul(w2, s)),
                        m_add(q, m_mul(w3, t)), m_sub(q, m_mul(w3, t))};
            end
            MODE_GS: begin
                p = m_add(a0, b0);
                q = m_mul(m_sub(a0, b0), w0);
                s = m_add(a1, b1);
                t = m_mul(m_sub(a1, b1), w1);
                e.r = '{m_add(p, s), m_mul(m_sub(p, s), w2),
                        m_add(q, t), m_mul(m_sub(q, t), w3)};
            end
            MODE_PWM: for (int i = 0; i < 4; i++) e.r[i] = m_mul(e.a[i], e.b[i]);
            MODE_PWA: for (int i = 0; i < 4; i++) e.r[i] = m_add(e.a[i], e.b[i]);
            default:  for (int i = 0; i < 4; i++) e.r[i] = m_sub(e.a[i], e.b[i]);
        endcase
        tbl[n_ent] = e;
        n_ent++;
    endtask

    task automatic add_rand(input op_mode_t m);
        coeff_t v [12];
        for (int i = 0; i < 12; i++) v[i] = rand_coeff();
        add_op(m, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10], v[11]);
    endtask

    // ------------------------------------------------------------------
    // Checks
    // ------------------------------------------------------------------
    task automatic check_coeff(input string name, input coeff_t got, input coeff_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail time=%0t signal=%s got=%0d expected=%0d", $time, name, got, exp);
        end
    endtask

    task automatic check_handshake(input logic ok, input string what);
        checks++;
        if (!ok) begin
            errors++;
            $display("Error at time %0t: %s", $time, what);
        end
    endtask

    function automatic logic hs_level(input int sel);
        return (sel == 0) ? ack_o : out_req_o;
    endfunction

    // Polls on the falling edge, so registered outputs are settled
    task automatic wait_level(input int sel, input logic lvl, input string what);
        int n;
        n = 0;
        while (hs_level(sel) !== lvl && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        check_handshake(hs_level(sel) === lvl, {"no ", what, " within the wait limit"});
    endtask

    // ------------------------------------------------------------------
    // Producer and consumer
    // ------------------------------------------------------------------
    task automatic send_op(input int idx);
        @(negedge clk);
        mode_i = tbl[idx].mode;
        {a0_i, a1_i, a2_i, a3_i} = {tbl[idx].a[0], tbl[idx].a[1], tbl[idx].a[2], tbl[idx].a[3]};
        {b0_i, b1_i, b2_i, b3_i} = {tbl[idx].b[0], tbl[idx].b[1], tbl[idx].b[2], tbl[idx].b[3]};
        {w0_i, w1_i, w2_i, w3_i} = {tbl[idx].w[0], tbl[idx].w[1], tbl[idx].w[2], tbl[idx].w[3]};
        req_i = 1'b1;
        wait_level(0, 1'b1, "ack_o rise");
        issued++;
        check_handshake(issued - consumed <= FIFO_DEPTH, "ack_o given while the queue was full");
        req_i = 1'b0;
        wait_level(0, 1'b0, "ack_o fall");
    endtask

    task automatic take_result(input int idx, input int delay);
        wait_level(1, 1'b1, "out_req_o rise");
        check_coeff("out_r0_o", out_r0_o, tbl[idx].r[0]);
        check_coeff("out_r1_o", out_r1_o, tbl[idx].r[1]);
        check_coeff("out_r2_o", out_r2_o, tbl[idx].r[2]);
        check_coeff("out_r3_o", out_r3_o, tbl[idx].r[3]);
        repeat (delay) @(negedge clk);
        out_ack_i = 1'b1;
        consumed++;
        wait_level(1, 1'b0, "out_req_o fall");
        out_ack_i = 1'b0;
    endtask

    task automatic run_test(input string name, input int first, input int cnt, input int delay);
        int err0;
        err0 = errors;
        issued = 0;
        consumed = 0;
        fork
            for (int k = 0; k < cnt; k++) send_op(first + k);
            for (int k = 0; k < cnt; k++) take_result(first + k, delay);
        join
        tests++;
        if (errors != err0) failed_tests++;
        $display("test %0d %s: %s (%0d errors)", tests, name,
                 (errors == err0) ? "ok" : "FAIL", errors - err0);
    endtask

    initial begin
        coeff_t x [4];
        coeff_t tw [4];
        int     err0, base;
        logic   stale;
        {reset_n, zeroize_i, req_i, out_ack_i} = 4'b0000;
        mode_i = MODE_CT;
        {a0_i, a1_i, a2_i, a3_i, b0_i, b1_i, b2_i, b3_i} = '0;
        {w0_i, w1_i, w2_i, w3_i} = '0;
        {n_ent, errors, checks, tests, failed_tests, cycles} = '0;
        lfsr_q = 23'd56502;

        // Forward, edge values then random
        add_op(MODE_CT, 0, NTT_Q-1, 0, NTT_Q-1, NTT_Q-1, 0, NTT_Q-1, 0,
               NTT_Q-1, NTT_Q-1, NTT_Q-1, NTT_Q-1);
        add_op(MODE_CT, NTT_Q-1, NTT_Q-1, NTT_Q-1, NTT_Q-1, NTT_Q-1, NTT_Q-1,
               NTT_Q-1, NTT_Q-1, 1, 0, NTT_Q-1, 2);
        add_rand(MODE_CT);
        add_rand(MODE_CT);
        // Inverse, random then a round trip with inverse twiddles
        add_rand(MODE_GS);
        add_rand(MODE_GS);
        for (int i = 0; i < 4; i++) x[i] = rand_coeff();
        // Twiddles in 1..Q-1, so each has an inverse
        for (int i = 0; i < 4; i++) tw[i] = coeff_t'(longint'(rand_coeff()) % (QL - 1) + 1);
        add_op(MODE_CT, x[0], x[1], 0, 0, x[2], x[3], 0, 0, tw[0], tw[1], tw[2], tw[3]);
        base = n_ent - 1;
        add_op(MODE_GS, tbl[base].r[0], tbl[base].r[2], 0, 0, tbl[base].r[1], tbl[base].r[3],
               0, 0, m_inv(tw[2]), m_inv(tw[3]), m_inv(tw[0]), m_inv(tw[1]));
        // Each stage doubles, so GS(CT(x)) is 4x
        tbl[n_ent-1].r = '{m_mul(x[0], 4), m_mul(x[2], 4), m_mul(x[1], 4), m_mul(x[3], 4)};
        // Pointwise
        add_op(MODE_PWM, NTT_Q-1, NTT_Q-1, 0, 1, NTT_Q-1, 2, 5, NTT_Q-1, 0, 0, 0, 0);
        add_op(MODE_PWA, NTT_Q-1, NTT_Q-1, 0, 7, 1, NTT_Q-1, 0, 9, 0, 0, 0, 0);
        add_op(MODE_PWS, 0, 3, NTT_Q-1, 0, 1, 3, 0, NTT_Q-1, 0, 0, 0, 0);
        add_rand(MODE_PWM);
        add_rand(MODE_PWS);
        // Back-pressure and mixed runs
        for (int i = 0; i < 8; i++) add_rand(op_mode_t'(i % 5));
        for (int i = 0; i < 6; i++) add_rand((i % 2 == 0) ? MODE_CT : op_mode_t'(2 + i / 2));
        // Zeroize: two flushed, one checked
        for (int i = 0; i < 3; i++) add_rand(op_mode_t'(i));
        timeout_limit = n_ent * (4 * BF_LATENCY + MAX_DELAY + 10);

        repeat (2) @(negedge clk);
        reset_n = 1'b1;
        check_handshake(ack_o === 1'b0 && out_req_o === 1'b0, "handshake outputs high after reset");

        run_test("forward butterflies", 0, 4, 1);
        run_test("inverse butterflies", 4, 4, 2);
        run_test("pointwise modes", 8, 5, 0);
        run_test("back-pressure and ordering", 13, 8, MAX_DELAY);
        run_test("mixed modes back to back", 21, 6, 0);

        // Zeroize with two operations in flight
        err0 = errors;
        issued = 0;
        consumed = 0;
        send_op(27);
        @(negedge clk);
        mode_i = tbl[28].mode;
        req_i = 1'b1;
        wait_level(0, 1'b1, "ack_o rise");
        // Req still high here, only the zeroize can drop ack
        zeroize_i = 1'b1;
        @(negedge clk);
        zeroize_i = 1'b0;
        req_i = 1'b0;
        check_handshake(ack_o === 1'b0 && out_req_o === 1'b0, "handshake outputs high after zeroize");
        stale = 1'b0;
        repeat (3 * BF_LATENCY + 4) begin
            @(negedge clk);
            if (out_req_o !== 1'b0) stale = 1'b1;
        end
        check_handshake(!stale, "a stale result appeared after zeroize");
        tests++;
        if (errors != err0) failed_tests++;
        $display("test %0d zeroize flush: %s (%0d errors)", tests,
                 (errors == err0) ? "ok" : "FAIL", errors - err0);
        run_test("operation after zeroize", 29, 1, 3);

        $display("tests %0d, failed tests %0d, checks %0d, errors %0d",
                 tests, failed_tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule
